// File: Makefile
# Verilator flow for the debug memory access unit testbench

VERILATOR ?= verilator
TOP       ?= tb_osd_mam
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Test FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "Test OK" $(LOG) || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/tb_ahb3_mem.sv
// AHB3 slave memory for the testbench, 4096 halfwords indexed by haddr[12:1]
// Every data phase is stretched by wait_states_i cycles with hready low
// Also reports the last accepted address and the number of accepted transfers

`timescale 1ns/1ps

module tb_ahb3_mem import mam_pkg::*; (
  input  logic       clk_i,
  input  logic       arst_n_i,
  input  logic [1:0] wait_states_i,
  input  logic       hsel_i,
  input  mam_addr_t  haddr_i,
  input  mam_data_t  hwdata_i,
  input  logic       hwrite_i,
  input  logic [1:0] htrans_i,
  output mam_data_t  hrdata_o,
  output logic       hready_o,
  output mam_addr_t  last_addr_o,
  output int         accesses_o
);

  mam_data_t   mem [4096];
  logic        dp_active_q;
  logic        dp_write_q;
  logic [11:0] dp_index_q;
  logic [1:0]  wait_cnt_q;

  // Fill pattern spreads every index bit over the word
  initial begin
    for (int i = 0; i < 4096; i++) begin
      mem[i] = 16'(i * 40503 + 4660);
    end
  end

  assign hready_o = !dp_active_q || (wait_cnt_q == 2'd0);
  assign hrdata_o = mem[dp_index_q];

  always @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      dp_active_q <= 1'b0;
      dp_write_q  <= 1'b0;
      dp_index_q  <= '0;
      wait_cnt_q  <= '0;
      last_addr_o <= '0;
      accesses_o  <= 0;
    end else if (hready_o) begin
      // Write completes at the end of its data phase
      if (dp_active_q && dp_write_q) mem[dp_index_q] <= hwdata_i;
      dp_active_q <= hsel_i && htrans_i[1];
      if (hsel_i && htrans_i[1]) begin
        dp_write_q  <= hwrite_i;
        dp_index_q  <= haddr_i[12:1];
        wait_cnt_q  <= wait_states_i;
        last_addr_o <= haddr_i;
        accesses_o  <= accesses_o + 1;
      end
    end else begin
      wait_cnt_q <= wait_cnt_q - 2'd1;
    end
  end

endmodule

// File: bench/tb_osd_mam.sv
// Directed testbench for the debug memory access unit with an AHB3 memory model
// Sends request packets on the debug port, checks the response packets and
// the bus activity seen by the memory model, then prints an error summary

`timescale 1ns/1ps

module tb_osd_mam import dii_pkg::*; import mam_pkg::*; ();

  localparam logic [15:0] MAM_ID  = 16'h0042;
  localparam logic [15:0] HOST_ID = 16'h0001;
  localparam int          TIMEOUT = 200;

  // Every access is one full data word
  localparam logic [2:0]  EXP_HSIZE = 3'($clog2(XLEN / 8));
  // AHB default protection for a privileged data access
  localparam logic [3:0]  EXP_HPROT = 4'b0011;

  logic        clk;
  logic        arst_n;
  dii_flit     debug_in;
  logic        debug_in_ready;
  dii_flit     debug_out;
  logic        debug_out_ready;
  logic        hsel, hwrite, hmastlock, hready;
  mam_addr_t   haddr, mem_last_addr;
  mam_data_t   hwdata, hrdata;
  logic [2:0]  hsize, hburst;
  logic [3:0]  hprot;
  logic [1:0]  htrans;
  logic [1:0]  wait_states;
  int          mem_accesses;
  integer      seed;
  logic [31:0] rnd;
  logic        stall_out;
  logic        bus_burst;
  int          value_errors, timeouts, other_errors;
  mam_data_t   exp_words [MAX_PKT_LEN];

  osd_mam_ahb3 u_osd_mam_ahb3 (
    .clk_i (clk), .arst_n_i (arst_n),
    .debug_in_i (debug_in), .debug_in_ready_o (debug_in_ready),
    .debug_out_o (debug_out), .debug_out_ready_i (debug_out_ready),
    .id_i (MAM_ID),
    .ahb3_hsel_o (hsel), .ahb3_haddr_o (haddr), .ahb3_hwdata_o (hwdata),
    .ahb3_hrdata_i (hrdata), .ahb3_hwrite_o (hwrite), .ahb3_hsize_o (hsize),
    .ahb3_hburst_o (hburst), .ahb3_hprot_o (hprot), .ahb3_htrans_o (htrans),
    .ahb3_hmastlock_o (hmastlock), .ahb3_hready_i (hready)
  );

  tb_ahb3_mem u_mem (
    .clk_i (clk), .arst_n_i (arst_n), .wait_states_i (wait_states),
    .hsel_i (hsel), .haddr_i (haddr), .hwdata_i (hwdata), .hwrite_i (hwrite),
    .htrans_i (htrans), .hrdata_o (hrdata), .hready_o (hready),
    .last_addr_o (mem_last_addr), .accesses_o (mem_accesses)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  task automatic check_data(input mam_data_t got, input mam_data_t exp, input string what);
    if (got !== exp) begin
      $display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
      value_errors++;
    end
  endtask

  task automatic check_flit(input dii_flit got, input dii_flit exp, input string what);
    if (got !== exp) begin
      $display("FAILED at %0t: %s is v%b l%b %h, expected v%b l%b %h", $time, what,
               got.valid, got.last, got.data, exp.valid, exp.last, exp.data);
      value_errors++;
    end
  endtask

  task automatic check_addr(input mam_addr_t got, input mam_addr_t exp, input string what);
    if (got !== exp) begin
      $display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
      value_errors++;
    end
  endtask

  // Controls packed as hsize, hburst, hprot, hmastlock
  task automatic check_ctrl(input logic [10:0] got, input logic [10:0] exp,
                            input string what);
    if (got !== exp) begin
      $display("FAILED at %0t: %s are %h, expected %h", $time, what, got, exp);
      value_errors++;
    end
  endtask

  // Every accepted address phase carries the controls of the current request
  always @(negedge clk) begin
    if (arst_n && hsel && htrans[1] && hready) begin
      check_ctrl({hsize, hburst, hprot, hmastlock},
                 {EXP_HSIZE, (bus_burst ? 3'b001 : 3'b000), EXP_HPROT, 1'b0},
                 "bus controls");
    end
  end

  function automatic logic [15:0] make_hdr(input logic we, input logic burst,
                                           input logic sync, input logic err,
                                           input mam_beats_t beats);
    logic [15:0] hdr;
    hdr                = {4'b0000, beats};
    hdr[DII_HDR_WE]    = we;
    hdr[DII_HDR_BURST] = burst;
    hdr[DII_HDR_SYNC]  = sync;
    hdr[DII_HDR_ERR]   = err;
    return hdr;
  endfunction

  // Ready does not depend on the flit, so it is stable from the falling edge on
  task automatic send_flit(input logic [15:0] data, input logic last);
    int waited;
    waited = 0;
    @(negedge clk);
    debug_in.valid = 1'b1;
    debug_in.last  = last;
    debug_in.data  = data;
    while (!debug_in_ready && waited < TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (!debug_in_ready) begin
      $display("ERROR at %0t: debug input never became ready", $time);
      timeouts++;
    end
    @(posedge clk);
  endtask

  task automatic idle_input();
    @(negedge clk);
    debug_in = '0;
  endtask

  task automatic send_request(input logic we, input logic burst, input logic sync,
                              input int beats, input mam_addr_t addr);
    bus_burst = burst;
    send_flit(MAM_ID, 1'b0);
    send_flit(HOST_ID, 1'b0);
    send_flit(make_hdr(we, burst, sync, 1'b0, mam_beats_t'(beats)), 1'b0);
    send_flit(addr[31:16], 1'b0);
    send_flit(addr[15:0], !we);
  endtask

  task automatic recv_flit(output dii_flit flit);
    int   waited;
    logic got;
    waited = 0;
    got    = 1'b0;
    flit   = '0;
    while (!got && waited < TIMEOUT) begin
      @(negedge clk);
      rnd             = $random(seed);
      debug_out_ready = stall_out ? rnd[0] : 1'b1;
      if (debug_out.valid && debug_out_ready) got = 1'b1;
      else waited++;
    end
    if (got) begin
      flit = debug_out;
    end else begin
      $display("ERROR at %0t: no response flit arrived", $time);
      timeouts++;
    end
  endtask

  // Read data are compared with exp_words in order
  task automatic expect_response(input logic sync, input logic err, input int beats,
                                 input int n_data);
    dii_flit got;
    dii_flit exp;
    exp.valid = 1'b1;
    exp.last  = 1'b0;
    exp.data  = HOST_ID;
    recv_flit(got);
    check_flit(got, exp, "response destination");
    exp.data = MAM_ID;
    recv_flit(got);
    check_flit(got, exp, "response source");
    exp.last = (n_data == 0);
    exp.data = make_hdr(1'b0, 1'b0, sync, err, mam_beats_t'(beats));
    recv_flit(got);
    check_flit(got, exp, "response header");
    for (int i = 0; i < n_data; i++) begin
      recv_flit(got);
      check_data(got.data, exp_words[i], "read beat");
      if (got.last !== (i == n_data - 1)) begin
        $display("FAILED at %0t: last flag of read beat %0d is %b", $time, i, got.last);
        value_errors++;
      end
    end
    @(negedge clk);
    debug_out_ready = 1'b0;
  endtask

  task automatic expect_silence();
    logic seen;
    seen = 1'b0;
    repeat (TIMEOUT) begin
      @(negedge clk);
      debug_out_ready = 1'b1;
      if (debug_out.valid) seen = 1'b1;
    end
    debug_out_ready = 1'b0;
    if (seen) begin
      $display("ERROR at %0t: a write without SYNC produced a response", $time);
      other_errors++;
    end
  endtask

  task automatic fill_words(input int n);
    for (int i = 0; i < n; i++) begin
      rnd          = $random(seed);
      exp_words[i] = rnd[15:0];
    end
  endtask

  task automatic write_words(input mam_addr_t addr, input logic burst, input logic sync,
                             input int n);
    send_request(1'b1, burst, sync, n, addr);
    for (int i = 0; i < n; i++) begin
      send_flit(exp_words[i], i == n - 1);
    end
    idle_input();
  endtask

  task automatic read_words(input mam_addr_t addr, input logic burst, input int n);
    send_request(1'b0, burst, 1'b0, n, addr);
    idle_input();
    expect_response(1'b0, 1'b0, n, n);
  endtask

  task automatic test_after_reset();
    @(negedge clk);
    if (debug_out.valid !== 1'b0 || hsel !== 1'b0 || htrans !== HTRANS_IDLE) begin
      $display("FAILED at %0t: outputs active right after reset", $time);
      value_errors++;
    end
  endtask

  task automatic test_single_access();
    fill_words(1);
    write_words(32'h0000_1010, 1'b0, 1'b0, 1);
    read_words(32'h0000_1010, 1'b0, 1);
  endtask

  task automatic test_burst();
    fill_words(MAX_PKT_LEN);
    write_words(32'h0000_0040, 1'b1, 1'b0, MAX_PKT_LEN);
    read_words(32'h0000_0040, 1'b1, MAX_PKT_LEN);
    check_addr(mem_last_addr, 32'h0000_0040 + 32'd14, "last bus address of burst");
  endtask

  task automatic test_sync_write();
    fill_words(1);
    write_words(32'h0000_0080, 1'b0, 1'b1, 1);
    expect_response(1'b1, 1'b0, 1, 0);
    write_words(32'h0000_0082, 1'b0, 1'b0, 1);
    expect_silence();
  endtask

  task automatic test_region_miss();
    int accesses_before;
    accesses_before = mem_accesses;
    send_request(1'b0, 1'b0, 1'b0, 1, 32'h0000_2000);
    idle_input();
    expect_response(1'b0, 1'b1, 1, 0);
    if (mem_accesses != accesses_before) begin
      $display("ERROR at %0t: bus access for an address outside the windows", $time);
      other_errors++;
    end
  endtask

  // Wait states on the bus and random stalls on the response port
  task automatic test_stalled_read();
    wait_states = 2'd2;
    fill_words(MAX_PKT_LEN);
    write_words(32'h0000_1080, 1'b1, 1'b0, MAX_PKT_LEN);
    stall_out = 1'b1;
    read_words(32'h0000_1080, 1'b1, MAX_PKT_LEN);
    stall_out   = 1'b0;
    wait_states = 2'd0;
  endtask

  initial begin
    seed            = 32'h0ebd8ea8;
    value_errors    = 0;
    timeouts        = 0;
    other_errors    = 0;
    debug_in        = '0;
    debug_out_ready = 1'b0;
    wait_states     = 2'd0;
    stall_out       = 1'b0;
    bus_burst       = 1'b0;
    arst_n          = 1'b0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;

    test_after_reset();
    test_single_access();
    test_burst();
    test_sync_write();
    test_region_miss();
    test_stalled_read();

    $display("Summary: %0d wrong values, %0d timeouts, %0d other errors",
             value_errors, timeouts, other_errors);
    if (value_errors + timeouts + other_errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// File: compile.f
src/dii_pkg.sv
src/mam_pkg.sv
src/mam_if.sv
src/osd_mam_regions.sv
src/osd_mam.sv
src/osd_mam_ahb3_if.sv
src/osd_mam_ahb3.sv
bench/tb_ahb3_mem.sv
bench/tb_osd_mam.sv

// File: src/dii_pkg.sv
// Debug interconnect definitions shared by every block on the debug network
// Holds the flit layout and the bit positions inside a packet header flit

package dii_pkg;

  // One 16-bit flit on the debug interconnect
  typedef struct packed {
    logic        valid;
    logic        last;
    logic [15:0] data;
  } dii_flit;

  // Header flit bits, the low 12 bits carry the beat count
  localparam int DII_HDR_WE    = 15;
  localparam int DII_HDR_BURST = 14;
  localparam int DII_HDR_SYNC  = 13;
  localparam int DII_HDR_ERR   = 12;

endpackage

// File: src/mam_if.sv
// Channels between the packet engine and the bus adapter
// The request channel stays valid until the last beat is done on the bus

`timescale 1ns/1ps

interface mam_req_if import mam_pkg::*; ();
  logic       req_valid;
  logic       req_ready;
  logic       req_we;
  mam_addr_t  req_addr;
  logic       req_burst;
  mam_beats_t req_beats;
  logic       req_sync;

  modport eng (output req_valid, req_we, req_addr, req_burst, req_beats, req_sync,
               input  req_ready);
  modport bus (input  req_valid, req_we, req_addr, req_burst, req_beats, req_sync,
               output req_ready);
endinterface

// Write beats flow to the bus, read beats flow back to the engine
interface mam_data_if import mam_pkg::*; ();
  logic      write_valid;
  mam_data_t write_data;
  logic      write_ready;
  logic      read_valid;
  mam_data_t read_data;
  logic      read_ready;

  modport eng (output write_valid, write_data, read_ready,
               input  write_ready, read_valid, read_data);
  modport bus (input  write_valid, write_data, read_ready,
               output write_ready, read_valid, read_data);
endinterface

// File: src/mam_pkg.sv
// Memory access unit definitions: bus widths, memory windows, request types
// and the AHB3 encodings used by the bus adapter

package mam_pkg;

  localparam int XLEN = 16;
  localparam int PLEN = 32;

  typedef logic [XLEN-1:0] mam_data_t;
  typedef logic [PLEN-1:0] mam_addr_t;
  typedef logic [11:0]     mam_beats_t;

  // Longest burst the unit accepts
  localparam int MAX_PKT_LEN = 8;

  // Memory windows the debugger may access
  localparam int        REGIONS    = 2;
  localparam mam_addr_t BASE_ADDR0 = 32'h0000_0000;
  localparam mam_addr_t MEM_SIZE0  = 32'd256;
  localparam mam_addr_t BASE_ADDR1 = 32'h0000_1000;
  localparam mam_addr_t MEM_SIZE1  = 32'd256;

  // AHB3 encodings
  localparam logic [1:0] HTRANS_IDLE   = 2'b00;
  localparam logic [1:0] HTRANS_BUSY   = 2'b01;
  localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
  localparam logic [1:0] HTRANS_SEQ    = 2'b11;
  localparam logic [2:0] HBURST_SINGLE = 3'b000;
  localparam logic [2:0] HBURST_INCR   = 3'b001;
  localparam logic [2:0] HSIZE_HALF    = 3'b001;
  localparam logic [3:0] HPROT_DATA    = 4'b0011;

  typedef enum logic [3:0] {
    MAM_DEST, MAM_SRC, MAM_HDR, MAM_ADDR_HI, MAM_ADDR_LO, MAM_CHECK, MAM_WRITE,
    MAM_DROP, MAM_WAIT, MAM_RESP_DEST, MAM_RESP_SRC, MAM_RESP_HDR, MAM_READ
  } mam_state_e;

endpackage

// File: src/osd_mam.sv
// Packet engine of the memory access unit
// Parses request packets from the debug network, issues one memory request
// per packet and returns read data or a write acknowledge as a response packet

`timescale 1ns/1ps

module osd_mam import dii_pkg::*; import mam_pkg::*; (
  input  logic           clk_i,
  input  logic           arst_n_i,
  input  dii_flit        debug_in_i,
  output logic           debug_in_ready_o,
  output dii_flit        debug_out_o,
  input  logic           debug_out_ready_i,
  input  logic [15:0]    id_i,
  mam_req_if.eng         req,
  mam_data_if.eng        data,
  output mam_addr_t      chk_addr_o,
  input  logic           region_hit_i
);

  mam_state_e  state_q, state_d;
  logic [15:0] src_q;
  logic [15:0] addr_hi_q;
  mam_addr_t   addr_q;
  logic        we_q, burst_q, sync_q;
  mam_beats_t  beats_q;
  mam_beats_t  beat_cnt_q;
  logic        err_q;
  logic        req_pending_q;
  logic        check_err;
  logic [15:0] resp_hdr;

  assign chk_addr_o = addr_q;
  assign check_err  = !region_hit_i || (beats_q == '0) || (beats_q > MAX_PKT_LEN);

  always_comb begin
    resp_hdr              = '0;
    resp_hdr[DII_HDR_SYNC] = sync_q;
    resp_hdr[DII_HDR_ERR]  = err_q;
    resp_hdr[11:0]         = beats_q;
  end

  assign req.req_valid = req_pending_q;
  assign req.req_we    = we_q;
  assign req.req_addr  = addr_q;
  assign req.req_burst = burst_q;
  assign req.req_beats = beats_q;
  assign req.req_sync  = sync_q;

  assign data.write_data = debug_in_i.data;

  always_comb begin
    state_d          = state_q;
    debug_in_ready_o = 1'b0;
    debug_out_o      = '0;
    data.write_valid = 1'b0;
    data.read_ready  = 1'b0;
    case (state_q)
      MAM_DEST, MAM_SRC, MAM_HDR, MAM_ADDR_HI, MAM_ADDR_LO: begin
        debug_in_ready_o = 1'b1;
        if (debug_in_i.valid) begin
          state_d = mam_state_e'(state_q + 4'd1);
        end
      end
      MAM_CHECK: begin
        if (check_err) state_d = we_q ? MAM_DROP : MAM_RESP_DEST;
        else           state_d = we_q ? MAM_WRITE : MAM_RESP_DEST;
      end
      MAM_WRITE: begin
        debug_in_ready_o = data.write_ready;
        data.write_valid = debug_in_i.valid;
        if (debug_in_i.valid && data.write_ready && debug_in_i.last) state_d = MAM_WAIT;
      end
      // Write data of a rejected request is swallowed
      MAM_DROP: begin
        debug_in_ready_o = 1'b1;
        if (debug_in_i.valid && debug_in_i.last) state_d = MAM_RESP_DEST;
      end
      MAM_WAIT: begin
        if (!req_pending_q) state_d = (we_q && sync_q) ? MAM_RESP_DEST : MAM_DEST;
      end
      MAM_RESP_DEST: begin
        debug_out_o.valid = 1'b1;
        debug_out_o.data  = src_q;
        if (debug_out_ready_i) state_d = MAM_RESP_SRC;
      end
      MAM_RESP_SRC: begin
        debug_out_o.valid = 1'b1;
        debug_out_o.data  = id_i;
        if (debug_out_ready_i) state_d = MAM_RESP_HDR;
      end
      MAM_RESP_HDR: begin
        debug_out_o.valid = 1'b1;
        debug_out_o.last  = err_q || we_q;
        debug_out_o.data  = resp_hdr;
        if (debug_out_ready_i) state_d = (err_q || we_q) ? MAM_DEST : MAM_READ;
      end
      MAM_READ: begin
        debug_out_o.valid = data.read_valid;
        debug_out_o.last  = (beat_cnt_q == beats_q - 1'b1);
        debug_out_o.data  = data.read_data;
        data.read_ready   = debug_out_ready_i;
        if (data.read_valid && debug_out_ready_i && debug_out_o.last) state_d = MAM_WAIT;
      end
      default: state_d = MAM_DEST;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q       <= MAM_DEST;
      err_q         <= 1'b0;
      req_pending_q <= 1'b0;
      beat_cnt_q    <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == MAM_CHECK) begin
        err_q         <= check_err;
        req_pending_q <= !check_err;
        beat_cnt_q    <= '0;
      end else begin
        if (req.req_valid && req.req_ready) req_pending_q <= 1'b0;
        if (data.read_valid && data.read_ready) beat_cnt_q <= beat_cnt_q + 1'b1;
      end
    end
  end

  // Packet fields, a single access always counts as one beat
  always_ff @(posedge clk_i) begin
    if (debug_in_i.valid) begin
      case (state_q)
        MAM_SRC: src_q <= debug_in_i.data;
        MAM_HDR: begin
          we_q    <= debug_in_i.data[DII_HDR_WE];
          burst_q <= debug_in_i.data[DII_HDR_BURST];
          sync_q  <= debug_in_i.data[DII_HDR_SYNC];
          beats_q <= debug_in_i.data[DII_HDR_BURST] ? mam_beats_t'(debug_in_i.data) : 12'd1;
        end
        MAM_ADDR_HI: addr_hi_q <= debug_in_i.data;
        MAM_ADDR_LO: addr_q <= {addr_hi_q, debug_in_i.data};
        default: ;
      endcase
    end
  end

  // A waiting request holds all its fields
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    req.req_valid && !req.req_ready |=> req.req_valid &&
      $stable({req.req_we, req.req_addr, req.req_burst, req.req_beats, req.req_sync}));

  // No request goes out for an address outside the windows
  assert property (@(posedge clk_i) disable iff (!arst_n_i) req.req_valid |-> region_hit_i);

endmodule

// File: src/osd_mam_ahb3.sv
// Debug memory access unit with an AHB3 master port
// Connects the packet engine, the address window check and the bus adapter

`timescale 1ns/1ps

module osd_mam_ahb3 import dii_pkg::*; import mam_pkg::*; (
  input  logic        clk_i,
  input  logic        arst_n_i,
  input  dii_flit     debug_in_i,
  output logic        debug_in_ready_o,
  output dii_flit     debug_out_o,
  input  logic        debug_out_ready_i,
  input  logic [15:0] id_i,
  output logic        ahb3_hsel_o,
  output mam_addr_t   ahb3_haddr_o,
  output mam_data_t   ahb3_hwdata_o,
  input  mam_data_t   ahb3_hrdata_i,
  output logic        ahb3_hwrite_o,
  output logic [2:0]  ahb3_hsize_o,
  output logic [2:0]  ahb3_hburst_o,
  output logic [3:0]  ahb3_hprot_o,
  output logic [1:0]  ahb3_htrans_o,
  output logic        ahb3_hmastlock_o,
  input  logic        ahb3_hready_i
);

  mam_addr_t chk_addr;
  logic      region_hit;

  mam_req_if  u_req_if ();
  mam_data_if u_data_if ();

  osd_mam u_mam (
    .clk_i             (clk_i),
    .arst_n_i          (arst_n_i),
    .debug_in_i        (debug_in_i),
    .debug_in_ready_o  (debug_in_ready_o),
    .debug_out_o       (debug_out_o),
    .debug_out_ready_i (debug_out_ready_i),
    .id_i              (id_i),
    .req               (u_req_if.eng),
    .data              (u_data_if.eng),
    .chk_addr_o        (chk_addr),
    .region_hit_i      (region_hit)
  );

  osd_mam_regions u_regions (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .chk_addr_i   (chk_addr),
    .region_hit_o (region_hit)
  );

  osd_mam_ahb3_if u_bus (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .req              (u_req_if.bus),
    .data             (u_data_if.bus),
    .ahb3_hsel_o      (ahb3_hsel_o),
    .ahb3_haddr_o     (ahb3_haddr_o),
    .ahb3_hwdata_o    (ahb3_hwdata_o),
    .ahb3_hrdata_i    (ahb3_hrdata_i),
    .ahb3_hwrite_o    (ahb3_hwrite_o),
    .ahb3_hsize_o     (ahb3_hsize_o),
    .ahb3_hburst_o    (ahb3_hburst_o),
    .ahb3_hprot_o     (ahb3_hprot_o),
    .ahb3_htrans_o    (ahb3_htrans_o),
    .ahb3_hmastlock_o (ahb3_hmastlock_o),
    .ahb3_hready_i    (ahb3_hready_i)
  );

endmodule

// File: src/osd_mam_ahb3_if.sv
// AHB3 master side of the memory access unit
// Turns one memory request into a SINGLE or an INCR burst with overlapped
// address and data phases, and acknowledges it after the last data phase

`timescale 1ns/1ps

module osd_mam_ahb3_if import mam_pkg::*; (
  input  logic       clk_i,
  input  logic       arst_n_i,
  mam_req_if.bus     req,
  mam_data_if.bus    data,
  output logic       ahb3_hsel_o,
  output mam_addr_t  ahb3_haddr_o,
  output mam_data_t  ahb3_hwdata_o,
  input  mam_data_t  ahb3_hrdata_i,
  output logic       ahb3_hwrite_o,
  output logic [2:0] ahb3_hsize_o,
  output logic [2:0] ahb3_hburst_o,
  output logic [3:0] ahb3_hprot_o,
  output logic [1:0] ahb3_htrans_o,
  output logic       ahb3_hmastlock_o,
  input  logic       ahb3_hready_i
);

  mam_beats_t addr_cnt_q;
  logic       all_issued_q;
  logic       aphase_last_q;
  logic       dphase_q, dphase_write_q, dphase_last_q;
  mam_data_t  wdata_a_q;
  mam_data_t  rbuf_q;
  logic       rbuf_valid_q;
  logic [1:0] rd_out_q;
  logic       issue_slot, rd_ok, wr_issue, rd_issue, issue, last_beat, req_ack, rd_take;

  // Only one read beat may be outstanding between bus and engine
  assign issue_slot = ahb3_hready_i && req.req_valid && !all_issued_q;
  assign rd_ok      = (rd_out_q == 2'd0) ||
                      ((rd_out_q == 2'd1) && rbuf_valid_q && data.read_ready);
  assign data.write_ready = issue_slot && req.req_we;
  assign wr_issue   = data.write_ready && data.write_valid;
  assign rd_issue   = issue_slot && !req.req_we && rd_ok;
  assign issue      = wr_issue || rd_issue;
  assign last_beat  = (addr_cnt_q == req.req_beats - 1'b1);
  assign req_ack    = ahb3_hready_i && dphase_q && dphase_last_q;
  assign rd_take    = ahb3_hready_i && dphase_q && !dphase_write_q;

  assign req.req_ready    = req_ack;
  assign data.read_valid  = rbuf_valid_q;
  assign data.read_data   = rbuf_q;
  assign ahb3_hsize_o     = HSIZE_HALF;
  assign ahb3_hprot_o     = HPROT_DATA;
  assign ahb3_hmastlock_o = 1'b0;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ahb3_hsel_o    <= 1'b0;
      ahb3_htrans_o  <= HTRANS_IDLE;
      ahb3_hwrite_o  <= 1'b0;
      ahb3_hburst_o  <= HBURST_SINGLE;
      addr_cnt_q     <= '0;
      all_issued_q   <= 1'b0;
      aphase_last_q  <= 1'b0;
      dphase_q       <= 1'b0;
      dphase_write_q <= 1'b0;
      dphase_last_q  <= 1'b0;
      rbuf_valid_q   <= 1'b0;
      rd_out_q       <= '0;
    end else begin
      if (ahb3_hready_i) begin
        // Accepted address phase becomes the data phase
        dphase_q       <= ahb3_htrans_o[1];
        dphase_write_q <= ahb3_hwrite_o;
        dphase_last_q  <= aphase_last_q;
        ahb3_hsel_o    <= req.req_valid && !req_ack;
        aphase_last_q  <= issue && last_beat;
        if (issue) begin
          ahb3_htrans_o <= (addr_cnt_q == '0) ? HTRANS_NONSEQ : HTRANS_SEQ;
          ahb3_hwrite_o <= req.req_we;
          ahb3_hburst_o <= req.req_burst ? HBURST_INCR : HBURST_SINGLE;
          addr_cnt_q    <= addr_cnt_q + 1'b1;
          all_issued_q  <= last_beat;
        end else if (req.req_valid && !all_issued_q && (addr_cnt_q != '0)) begin
          // Burst stalled on data, keep it open
          ahb3_htrans_o <= HTRANS_BUSY;
        end else begin
          ahb3_htrans_o <= HTRANS_IDLE;
        end
        if (req_ack) begin
          addr_cnt_q   <= '0;
          all_issued_q <= 1'b0;
        end
      end
      if (rd_take)              rbuf_valid_q <= 1'b1;
      else if (data.read_ready) rbuf_valid_q <= 1'b0;
      rd_out_q <= rd_out_q + {1'b0, rd_issue} - {1'b0, rbuf_valid_q && data.read_ready};
    end
  end

  // Write data follows its address by one accepted phase
  always_ff @(posedge clk_i) begin
    if (issue) begin
      ahb3_haddr_o <= (addr_cnt_q == '0) ? req.req_addr : ahb3_haddr_o + mam_addr_t'(XLEN/8);
      wdata_a_q    <= data.write_data;
    end
    if (ahb3_hready_i) ahb3_hwdata_o <= wdata_a_q;
    if (rd_take)       rbuf_q        <= ahb3_hrdata_i;
  end

  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !ahb3_hsel_o |-> ahb3_htrans_o == HTRANS_IDLE);

endmodule

// File: src/osd_mam_regions.sv
// Address window check for the memory access unit
// Returns a hit in the same cycle when any configured window holds the address

`timescale 1ns/1ps

module osd_mam_regions import mam_pkg::*; (
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  mam_addr_t chk_addr_i,
  output logic      region_hit_o
);

  logic [REGIONS-1:0] hit_vec;

  function automatic logic in_window(mam_addr_t addr, mam_addr_t base, mam_addr_t size);
    return (addr >= base) && ((addr - base) < size);
  endfunction

  // All windows are compared in parallel
  assign hit_vec[0]   = in_window(chk_addr_i, BASE_ADDR0, MEM_SIZE0);
  assign hit_vec[1]   = in_window(chk_addr_i, BASE_ADDR1, MEM_SIZE1);
  assign region_hit_o = |hit_vec;

endmodule
